// ==== sw_cfg_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Switch bank sizing
//////////////////////////////////////////////////

package sw_cfg_pkg;

   // Upper bound on switches in one bank
   localparam int unsigned MAX_SW = 8;

   // Index width, enough to name any of MAX_SW switches
   localparam int unsigned SW_IDX_W = 3;

   //////////////////////////////////////////////////
   // Defaults picked up by the top level
   //////////////////////////////////////////////////

   // Stability counter width
   // 2^(bits-2) stable cycles accept a new level
   localparam int unsigned DEF_DEBOUNCE_BITS = 14;

   // Event queue entries, power of two
   localparam int unsigned DEF_FIFO_DEPTH = 8;

endpackage : sw_cfg_pkg

`default_nettype wire

// ==== evt_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Event record encodings
//////////////////////////////////////////////////

package evt_pkg;

   // Event opcode stored in the queue
   // Switches are active low, a press is a debounced fall
   typedef enum logic
   {
      EVT_PRESS   = 1'b0,
      EVT_RELEASE = 1'b1
   } evt_kind_e;

   // Per-channel holder state
   // One event can wait for the queue at a time
   typedef enum logic
   {
      CH_IDLE    = 1'b0,
      CH_PENDING = 1'b1
   } ch_state_e;

endpackage : evt_pkg

`default_nettype wire

// ==== debounce.sv ====
`default_nettype none

module debounce #(
   parameter int unsigned DEBOUNCE_BITS = 14
) (
   input  logic clk_i,
   input  logic resetn_i,
   input  logic switch_i,
   output logic level_o,
   output logic press_o,
   output logic release_o
);

   // Top bit of the stability counter doubles as its saturation flag
   localparam int unsigned CNT_MSB = DEBOUNCE_BITS - 2;

   // Two-flop synchronizer
   logic             sync1_q;
   logic             sync2_q;
   // Stability counter
   logic [CNT_MSB:0] cnt_q;
   logic             cnt_clr;
   logic             cnt_sat;
   // Debounced level is high while pressed
   logic             level_q;
   // Edge detector delay line
   logic             level_d1_q;
   logic             level_d2_q;
   logic             press_q;
   logic             release_q;

   if (DEBOUNCE_BITS < 3)
   begin : g_bad_bits
      $error("debounce: DEBOUNCE_BITS must be at least 3");
   end

   //////////////////////////////////////////////////
   // Synchronizer and stability counter
   //////////////////////////////////////////////////

   // Any difference between the flops restarts the count
   assign cnt_clr = sync1_q ^ sync2_q;
   assign cnt_sat = cnt_q[CNT_MSB];

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         // Released switch idles high
         sync1_q <= 1'b1;
         sync2_q <= 1'b1;
      end
      else
      begin
         sync1_q <= switch_i;
         sync2_q <= sync1_q;
      end
   end

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
         cnt_q <= '0;
      else if (cnt_clr)
         cnt_q <= '0;
      else if (!cnt_sat)
         cnt_q <= cnt_q + 1'b1;   // holds once the top bit is set
   end

   //////////////////////////////////////////////////
   // Debounced level and edge pulses
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         level_q    <= 1'b0;
         level_d1_q <= 1'b0;
         level_d2_q <= 1'b0;
         press_q    <= 1'b0;
         release_q  <= 1'b0;
      end
      else
      begin
         // Inverted so a low input reads as pressed
         if (cnt_sat)
            level_q <= ~sync2_q;
         level_d1_q <= level_q;
         level_d2_q <= level_d1_q;
         // One-cycle pulses two cycles behind the level
         press_q    <= level_d1_q & ~level_d2_q;
         release_q  <= ~level_d1_q & level_d2_q;
      end
   end

   assign level_o   = level_q;
   assign press_o   = press_q;
   assign release_o = release_q;

   // The stability count keeps the new level in place until its pulse is out
   assert property (@(posedge clk_i) disable iff (!resetn_i)
      press_o |-> level_o);
   assert property (@(posedge clk_i) disable iff (!resetn_i)
      release_o |-> !level_o);

endmodule : debounce

`default_nettype wire

// ==== sw_channel.sv ====
`default_nettype none

module sw_channel #(
   parameter int unsigned DEBOUNCE_BITS = 14
) (
   input  logic               clk_i,
   input  logic               resetn_i,
   input  logic               switch_i,
   input  logic               gnt_i,
   output logic               req_o,
   output evt_pkg::evt_kind_e kind_o,
   output logic               overrun_o
);

   import evt_pkg::*;

   logic      press;
   logic      release_p;
   logic      pulse;
   ch_state_e state_q;
   evt_kind_e kind_q;
   logic      overrun_q;

   // Clean edge source, level itself not needed here
   debounce #(
      .DEBOUNCE_BITS (DEBOUNCE_BITS)
   ) i_debounce (
      .clk_i     (clk_i),
      .resetn_i  (resetn_i),
      .switch_i  (switch_i),
      .level_o   (),
      .press_o   (press),
      .release_o (release_p)
   );

   assign pulse = press | release_p;

   //////////////////////////////////////////////////
   // One-deep pending event
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         state_q   <= CH_IDLE;
         overrun_q <= 1'b0;
      end
      else if (pulse)
      begin
         // Holder still busy, drop the new event
         if (state_q == CH_PENDING && !gnt_i)
            overrun_q <= 1'b1;
         else
            state_q <= CH_PENDING;
      end
      else if (gnt_i)
         state_q <= CH_IDLE;
   end

   // Kind follows an accepted pulse
   always_ff @(posedge clk_i)
   begin
      if (pulse && (state_q == CH_IDLE || gnt_i))
         kind_q <= press ? EVT_PRESS : EVT_RELEASE;
   end

   assign req_o     = (state_q == CH_PENDING);
   assign kind_o    = kind_q;
   assign overrun_o = overrun_q;

   // Arbiter only grants a requesting channel
   assert property (@(posedge clk_i) disable iff (!resetn_i)
      (state_q == CH_IDLE) |-> !gnt_i);

endmodule : sw_channel

`default_nettype wire

// ==== event_arbiter.sv ====
`default_nettype none

module event_arbiter #(
   parameter int unsigned NUM_SW = 4
) (
   input  logic                              clk_i,
   input  logic                              resetn_i,
   input  logic [NUM_SW-1:0]                 req_i,
   input  logic                              full_i,
   output logic [NUM_SW-1:0]                 gnt_o,
   output logic [sw_cfg_pkg::SW_IDX_W-1:0]   gnt_idx_o,
   output logic                              wr_en_o
);

   import sw_cfg_pkg::*;

   // Last granted index
   logic [SW_IDX_W-1:0] ptr_q;
   logic [NUM_SW-1:0]   gnt;
   logic [SW_IDX_W-1:0] gnt_idx;
   logic                found;

   //////////////////////////////////////////////////
   // Rotating priority search
   //////////////////////////////////////////////////

   // Scan starts one past the pointer and wraps
   always_comb
   begin
      int cand;
      gnt     = '0;
      gnt_idx = '0;
      found   = 1'b0;
      for (int off = 1; off <= int'(NUM_SW); off++)
      begin
         cand = int'(ptr_q) + off;
         if (cand >= int'(NUM_SW))
            cand = cand - int'(NUM_SW);
         // First requester wins, nothing while the queue is full
         if (!found && !full_i && req_i[cand])
         begin
            found      = 1'b1;
            gnt[cand]  = 1'b1;
            gnt_idx    = cand[SW_IDX_W-1:0];
         end
      end
   end

   // Pointer moves onto the winner
   // Reset value puts index 0 first
   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
         ptr_q <= SW_IDX_W'(NUM_SW - 1);
      else if (found)
         ptr_q <= gnt_idx;
   end

   assign gnt_o     = gnt;
   assign gnt_idx_o = gnt_idx;
   assign wr_en_o   = |gnt;

   // At most one writer per cycle
   assert property (@(posedge clk_i) disable iff (!resetn_i)
      $onehot0(gnt_o));

endmodule : event_arbiter

`default_nettype wire

// ==== event_fifo.sv ====
`default_nettype none

module event_fifo #(
   parameter int unsigned FIFO_DEPTH = 8
) (
   input  logic                            clk_i,
   input  logic                            resetn_i,
   input  logic                            wr_en_i,
   input  logic [sw_cfg_pkg::SW_IDX_W-1:0] wr_idx_i,
   input  evt_pkg::evt_kind_e              wr_kind_i,
   input  logic                            pop_i,
   output logic                            full_o,
   output logic                            evt_valid_o,
   output logic [sw_cfg_pkg::SW_IDX_W-1:0] evt_idx_o,
   output evt_pkg::evt_kind_e              evt_kind_o
);

   import sw_cfg_pkg::*;
   import evt_pkg::*;

   localparam int unsigned AW = $clog2(FIFO_DEPTH);

   // Entry storage, index and kind side by side
   logic [SW_IDX_W-1:0] mem_idx [FIFO_DEPTH];
   evt_kind_e           mem_kind [FIFO_DEPTH];

   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;
   logic          empty;
   logic          full;
   logic          do_wr;
   logic          do_rd;

   if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0)
   begin : g_bad_depth
      $error("event_fifo: FIFO_DEPTH must be a power of two, at least 2");
   end

   assign empty = (count_q == '0);
   assign full  = (count_q == (AW+1)'(FIFO_DEPTH));

   // Pop on an empty queue is ignored
   assign do_wr = wr_en_i & ~full;
   assign do_rd = pop_i & ~empty;

   //////////////////////////////////////////////////
   // Pointers and occupancy
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge resetn_i)
   begin
      if (!resetn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         // Power-of-two depth, pointers wrap on their own
         if (do_wr)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (do_wr && !do_rd)
            count_q <= count_q + 1'b1;
         else if (do_rd && !do_wr)
            count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (do_wr)
      begin
         mem_idx[wr_ptr_q]  <= wr_idx_i;
         mem_kind[wr_ptr_q] <= wr_kind_i;
      end
   end

   // Fall-through head
   assign evt_valid_o = ~empty;
   assign evt_idx_o   = mem_idx[rd_ptr_q];
   assign evt_kind_o  = mem_kind[rd_ptr_q];
   assign full_o      = full;

   // Arbiter withholds grants while full
   assert property (@(posedge clk_i) disable iff (!resetn_i)
      full |-> !wr_en_i);

endmodule : event_fifo

`default_nettype wire

// ==== sw_debounce_top.sv ====
`default_nettype none

module sw_debounce_top #(
   parameter int unsigned NUM_SW        = 4,
   parameter int unsigned DEBOUNCE_BITS = sw_cfg_pkg::DEF_DEBOUNCE_BITS,
   parameter int unsigned FIFO_DEPTH    = sw_cfg_pkg::DEF_FIFO_DEPTH
) (
   input  logic                            clk_i,
   input  logic                            resetn_i,
   input  logic [NUM_SW-1:0]               switch_i,
   input  logic                            pop_i,
   output logic                            evt_valid_o,
   output logic [sw_cfg_pkg::SW_IDX_W-1:0] evt_idx_o,
   output evt_pkg::evt_kind_e              evt_kind_o,
   output logic [NUM_SW-1:0]               overrun_o
);

   import sw_cfg_pkg::*;
   import evt_pkg::*;

   logic [NUM_SW-1:0]   req;
   logic [NUM_SW-1:0]   gnt;
   evt_kind_e           ch_kind [NUM_SW];
   logic [SW_IDX_W-1:0] gnt_idx;
   logic                wr_en;
   evt_kind_e           wr_kind;
   logic                full;

   if (NUM_SW < 1 || NUM_SW > MAX_SW)
   begin : g_bad_num_sw
      $error("sw_debounce_top: NUM_SW out of range");
   end

   //////////////////////////////////////////////////
   // Switch channels
   //////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_SW; i++)
   begin : g_ch
      sw_channel #(
         .DEBOUNCE_BITS (DEBOUNCE_BITS)
      ) i_sw_channel (
         .clk_i     (clk_i),
         .resetn_i  (resetn_i),
         .switch_i  (switch_i[i]),
         .gnt_i     (gnt[i]),
         .req_o     (req[i]),
         .kind_o    (ch_kind[i]),
         .overrun_o (overrun_o[i])
      );
   end

   // Kind of the granted channel goes to the queue
   always_comb
   begin
      wr_kind = EVT_PRESS;
      for (int i = 0; i < int'(NUM_SW); i++)
      begin
         if (gnt[i])
            wr_kind = ch_kind[i];
      end
   end

   event_arbiter #(
      .NUM_SW (NUM_SW)
   ) i_event_arbiter (
      .clk_i     (clk_i),
      .resetn_i  (resetn_i),
      .req_i     (req),
      .full_i    (full),
      .gnt_o     (gnt),
      .gnt_idx_o (gnt_idx),
      .wr_en_o   (wr_en)
   );

   event_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_event_fifo (
      .clk_i       (clk_i),
      .resetn_i    (resetn_i),
      .wr_en_i     (wr_en),
      .wr_idx_i    (gnt_idx),
      .wr_kind_i   (wr_kind),
      .pop_i       (pop_i),
      .full_o      (full),
      .evt_valid_o (evt_valid_o),
      .evt_idx_o   (evt_idx_o),
      .evt_kind_o  (evt_kind_o)
   );

endmodule : sw_debounce_top

`default_nettype wire

// ==== tb_sw_debounce.sv ====
`default_nettype none

module tb_sw_debounce;

   timeunit 1ns;
   timeprecision 1ps;

   import sw_cfg_pkg::*;
   import evt_pkg::*;

   localparam int unsigned NUM_SW        = 4;
   localparam int unsigned DEBOUNCE_BITS = 6;
   localparam int unsigned FIFO_DEPTH    = 4;
   localparam int unsigned RESET_CYCLES  = 16;
   // Slack on top of the summed trace hold time
   localparam int unsigned TIMEOUT_SLACK = 200;

   logic                clk_i;
   logic                resetn_i;
   logic [NUM_SW-1:0]   switch_i;
   logic                pop_i;
   logic                evt_valid_o;
   logic [SW_IDX_W-1:0] evt_idx_o;
   evt_kind_e           evt_kind_o;
   logic [NUM_SW-1:0]   overrun_o;

   // Parsed trace with one entry per command line
   byte                 cmd_q [$];
   int                  arg_a_q [$];
   int                  arg_b_q [$];

   // Bounce source
   integer              seed = 76;
   // Watchdog
   int                  cycle_cnt = 0;
   int                  cycle_limit = TIMEOUT_SLACK;
   // Settled switch vector with switch 0 in the low bit
   logic [NUM_SW-1:0]   sw_vec;

   //////////////////////////////////////////////////
   // DUT and clock
   //////////////////////////////////////////////////

   sw_debounce_top #(
      .NUM_SW        (NUM_SW),
      .DEBOUNCE_BITS (DEBOUNCE_BITS),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) i_sw_debounce_top (
      .clk_i       (clk_i),
      .resetn_i    (resetn_i),
      .switch_i    (switch_i),
      .pop_i       (pop_i),
      .evt_valid_o (evt_valid_o),
      .evt_idx_o   (evt_idx_o),
      .evt_kind_o  (evt_kind_o),
      .overrun_o   (overrun_o)
   );

   // 40 ns period
   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // Run length is bounded by the trace itself
   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit)
         abort_run($sformatf("Timeout after %0d cycles, trace did not complete", cycle_cnt));
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_event(input logic [SW_IDX_W-1:0] exp_idx, input evt_kind_e exp_kind);
      if (evt_idx_o !== exp_idx)
         abort_run($sformatf("Error: evt_idx_o = 0x%h, expected 0x%h", evt_idx_o, exp_idx));
      if (evt_kind_o !== exp_kind)
         abort_run($sformatf("Error: evt_kind_o = 0x%h, expected 0x%h",
                             evt_kind_o, exp_kind));
   endtask

   task automatic check_no_event();
      if (evt_valid_o !== 1'b0)
         abort_run($sformatf("Error: evt_valid_o = 0x%h, expected 0x0", evt_valid_o));
   endtask

   task automatic check_overrun(input logic [NUM_SW-1:0] exp_mask);
      if (overrun_o !== exp_mask)
         abort_run($sformatf("Error: overrun_o = 0x%h, expected 0x%h", overrun_o, exp_mask));
   endtask

   // One-cycle strobe launched on the falling edge
   task automatic strobe_pop();
      pop_i = 1'b1;
      @(negedge clk_i);
      pop_i = 1'b0;
   endtask

   // Wait for a head entry since the pulse latency varies
   task automatic pop_event(input logic [SW_IDX_W-1:0] exp_idx, input evt_kind_e exp_kind);
      while (evt_valid_o !== 1'b1)
         @(negedge clk_i);
      check_event(exp_idx, exp_kind);
      strobe_pop();
   endtask

   // Random chatter on one switch while the others keep the settled vector
   task automatic bounce_switch(input int idx, input int cycles);
      logic [NUM_SW-1:0] vec;
      logic [31:0]       rnd;
      vec = sw_vec;
      repeat (cycles)
      begin
         rnd      = $random(seed);
         vec[idx] = rnd[0];
         switch_i = vec;
         @(negedge clk_i);
      end
   endtask

   task automatic run_command(input byte cmd, input int a, input int b);
      case (cmd)
         "S":
         begin
            sw_vec   = a[NUM_SW-1:0];
            switch_i = sw_vec;
            repeat (b) @(negedge clk_i);
         end
         "B": bounce_switch(a, b);
         "E": pop_event(a[SW_IDX_W-1:0], evt_kind_e'(b[0]));
         "N": check_no_event();
         "P":
         begin
            // Pop on an empty queue must leave it unchanged
            check_no_event();
            strobe_pop();
         end
         "O": check_overrun(a[NUM_SW-1:0]);
         default: abort_run($sformatf("Unknown trace command '%c'", cmd));
      endcase
   endtask

   // Whole trace read up front so the timeout is known before reset
   task automatic load_trace();
      int    fd;
      string line;
      byte   cmd;
      int    a;
      int    b;
      int    n;
      fd = $fopen("sw_trace.txt", "r");
      if (fd == 0)
         abort_run("Could not open the trace file sw_trace.txt");
      while (!$feof(fd))
      begin
         line = "";
         cmd  = 0;
         a    = 0;
         b    = 0;
         void'($fgets(line, fd));
         n = $sscanf(line, "%c %h %d", cmd, a, b);
         if (n >= 1)
         begin
            case (cmd)
               "S", "B":
               begin
                  cmd_q.push_back(cmd);
                  arg_a_q.push_back(a);
                  arg_b_q.push_back(b);
                  cycle_limit += b;
               end
               "E", "N", "P", "O":
               begin
                  cmd_q.push_back(cmd);
                  arg_a_q.push_back(a);
                  arg_b_q.push_back(b);
               end
               // Comments and blank lines
               default: ;
            endcase
         end
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      // Switches idle high when released
      sw_vec   = '1;
      switch_i = '1;
      pop_i    = 1'b0;
      resetn_i = 1'b0;
      load_trace();
      $display("Trace holds %0d commands, cycle limit %0d", cmd_q.size(), cycle_limit);
      repeat (RESET_CYCLES) @(negedge clk_i);
      resetn_i = 1'b1;
      @(negedge clk_i);
      // No queued event and no overrun straight out of reset
      check_no_event();
      check_overrun('0);
      for (int i = 0; i < cmd_q.size(); i++)
         run_command(cmd_q[i], arg_a_q[i], arg_b_q[i]);
      $display(">>> PASS");
      $finish;
   end

endmodule : tb_sw_debounce

`default_nettype wire

// ==== sw_trace.txt ====
# S vec(hex) cycles : drive switch vector, hold | B idx cycles : bounce one switch
# E idx kind : expect and pop, kind 0 press 1 release | N : none queued | P : pop empty | O mask
# All switches pressed then released together, rotation from index 0
S 0 30
E 0 0
E 1 0
E 2 0
E 3 0
S F 30
E 0 1
E 1 1
E 2 1
E 3 1
# Clean press and release on switch 1
S D 30
E 1 0
S F 30
E 1 1
N
# Bounce settling pressed, then bounce back to pressed
B 2 12
S B 30
E 2 0
B 2 12
S B 30
N
S F 30
E 2 1
B 2 12
S F 30
N
# Fill the queue with no pops, switch 0 release stays pending
S E 30
S C 30
S 8 30
S 0 30
S 1 30
O 0
S 0 30
O 1
E 0 0
E 1 0
E 2 0
E 3 0
E 0 1
N
# Release all, rotation resumes after index 0
S F 30
E 1 1
E 2 1
E 3 1
E 0 1
# Pop while empty changes nothing
P
N
S E 30
E 0 0
S F 30
E 0 1
O 1

// ==== sources.f ====
sw_cfg_pkg.sv
evt_pkg.sv
debounce.sv
sw_channel.sv
event_arbiter.sv
event_fifo.sv
sw_debounce_top.sv
tb_sw_debounce.sv

// ==== Bender.yml ====
package:
  name: sw_debounce

sources:
  # Packages first
  - sw_cfg_pkg.sv
  - evt_pkg.sv
  # RTL
  - debounce.sv
  - sw_channel.sv
  - event_arbiter.sv
  - event_fifo.sv
  - sw_debounce_top.sv
  # Testbench
  - target: test
    files:
      - tb_sw_debounce.sv
